//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_wg_fifo
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/wg_fifo.sv
// weight-group FIFO top level
// 128 x 5 synchronous FIFO with request/ready on both sides;
// write side, folded RAM and read side joined by the RAM port bundle
// and a registered push/pop boundary

module wg_fifo
    import wg_fifo_pkg::*;
(
    input  logic       clk_mgated,
    input  logic       reset_,
    input  logic       wr_req,
    output logic       wr_ready,
    input  fifo_data_t wr_data,
    output logic       rd_req,
    input  logic       rd_ready,
    output fifo_data_t rd_data
);

    // word entered the RAM this cycle
    logic pushing;
    // word left the prefetch stage this cycle
    logic popping;

    // RAM ports between the controllers and the folded RAM
    wg_fifo_ram_if ram_if ();

    // ====================
    // write side
    // ====================

    wg_fifo_wr_ctrl u_wr_ctrl (
        .clk_mgated (clk_mgated),
        .reset_     (reset_),
        .wr_req     (wr_req),
        .wr_ready   (wr_ready),
        .wr_data    (wr_data),
        .popping    (popping),
        .pushing    (pushing),
        .ram        (ram_if.writer)
    );

    // storage
    wg_fifo_folded_ram u_folded_ram (
        .clk_mgated (clk_mgated),
        .reset_     (reset_),
        .ram        (ram_if.ram)
    );

    // ====================
    // read side
    // ====================

    wg_fifo_rd_ctrl u_rd_ctrl (
        .clk_mgated (clk_mgated),
        .reset_     (reset_),
        .rd_req     (rd_req),
        .rd_ready   (rd_ready),
        .rd_data    (rd_data),
        .pushing    (pushing),
        .popping    (popping),
        .ram        (ram_if.reader)
    );

endmodule

//--- rtl/wg_fifo_folded_ram.sv
// weight-group FIFO folded RAM
// presents a 128 x 5 RAM built from a 64 x 10 array; a two-entry
// collection buffer gathers each row before it is written, reads hit
// the buffer when the entry is there and otherwise read the array
// once per row and pick the half from the registered low address bit

module wg_fifo_folded_ram
    import wg_fifo_pkg::*;
(
    input  logic       clk_mgated,
    input  logic       reset_,
    wg_fifo_ram_if.ram ram
);

    // collection buffer and the address last written into it
    row_data_t  buff;
    fifo_adr_t  buff_wa;
    row_adr_t   buff_wa_f;
    row_adr_t   ra_f;

    // buffer bypass
    logic       same_addr_write_and_read;
    logic       use_buff_d_next;
    logic       use_buff_d;
    fifo_data_t buff_d;

    // array control
    logic       we_f;
    logic       re_f;
    logic       did_re_f;
    row_data_t  dout_f;
    logic       ro_d;
    fifo_data_t dout_fm;

    assign buff_wa_f = buff_wa[ADR_W-1:1];
    assign ra_f      = ram.ra[ADR_W-1:1];

    // ====================
    // bypass decision
    // ====================

    assign same_addr_write_and_read = ram.we && ram.re && (ram.wa == ram.ra);

    // entry already sits in the buffer row
    assign use_buff_d_next = ((ra_f == buff_wa_f) && (buff_wa[0] >= ram.ra[0]))
                          || same_addr_write_and_read;

    // flush the previous row when a new one starts
    assign we_f = ram.we && !ram.wa[0];

    // one array read per row
    assign re_f = ram.re && !use_buff_d_next && (!ram.ra[0] || !did_re_f);

    // ====================
    // control state
    // ====================

    always_ff @(posedge clk_mgated or negedge reset_) begin
        if (!reset_) begin
            buff_wa    <= '0;
            did_re_f   <= 1'b0;
            use_buff_d <= 1'b0;
            ro_d       <= 1'b0;
        end else begin
            if (ram.we) begin
                buff_wa <= ram.wa;
            end
            // row stays open until the second half is read
            did_re_f <= re_f || (!use_buff_d_next && did_re_f && ram.ra[0]);
            if (ram.re) begin
                use_buff_d <= use_buff_d_next;
                if (!use_buff_d_next) begin
                    ro_d <= ram.ra[0];
                end
            end
        end
    end

    // ====================
    // buffer data
    // ====================

    always_ff @(posedge clk_mgated) begin
        if (ram.we) begin
            if (ram.wa[0]) begin
                buff[ROW_DATA_W-1:DATA_W] <= ram.di;
            end else begin
                buff[DATA_W-1:0] <= ram.di;
            end
        end
        // snapshot of the bypassed entry
        if (ram.re && use_buff_d_next) begin
            if (ram.ra[0]) begin
                buff_d <= buff[ROW_DATA_W-1:DATA_W];
            end else begin
                buff_d <= buff[DATA_W-1:0];
            end
        end
    end

    wg_fifo_ram_array u_ram_array (
        .clk_mgated (clk_mgated),
        .wa         (buff_wa_f),
        .we         (we_f),
        .di         (buff),
        .ra         (ra_f),
        .re         (re_f),
        .dout       (dout_f)
    );

    // half select of the last array read
    assign dout_fm = ro_d ? dout_f[ROW_DATA_W-1:DATA_W] : dout_f[DATA_W-1:0];

    assign ram.dout = use_buff_d ? buff_d : dout_fm;

endmodule

//--- rtl/wg_fifo_pkg.sv
// weight-group FIFO shared definitions
// geometry of the 128 x 5 FIFO and of its folded 64 x 10 RAM
// vector types for entries, addresses, counts and RAM rows

package wg_fifo_pkg;

    // ====================
    // FIFO geometry
    // ====================

    // number of entries
    localparam int FIFO_DEPTH = 128;
    // bits per entry
    localparam int DATA_W     = 5;
    // entry address, low bit picks the row half
    localparam int ADR_W      = 7;
    // count must reach FIFO_DEPTH itself
    localparam int CNT_W      = 8;

    // ====================
    // folded RAM geometry
    // ====================

    // 64 rows
    localparam int ROW_W      = 6;
    // two entries per row
    localparam int ROW_DATA_W = 10;

    // one entry
    typedef logic [DATA_W-1:0]     fifo_data_t;
    // entry address
    typedef logic [ADR_W-1:0]      fifo_adr_t;
    // occupancy count
    typedef logic [CNT_W-1:0]      fifo_cnt_t;
    // row address into the array
    typedef logic [ROW_W-1:0]      row_adr_t;
    // one full row
    typedef logic [ROW_DATA_W-1:0] row_data_t;

endpackage

//--- rtl/wg_fifo_ram_array.sv
// weight-group FIFO storage array
// 64 rows of 10 bits, synchronous write, read data registered on re

module wg_fifo_ram_array
    import wg_fifo_pkg::*;
(
    input  logic      clk_mgated,
    input  row_adr_t  wa,
    input  logic      we,
    input  row_data_t di,
    input  row_adr_t  ra,
    input  logic      re,
    output row_data_t dout
);

    // storage
    row_data_t mem [0:(2**ROW_W)-1];

    // write port
    always_ff @(posedge clk_mgated) begin
        if (we) begin
            mem[wa] <= di;
        end
    end

    // read port, old data on a same-row collision
    always_ff @(posedge clk_mgated) begin
        if (re) begin
            dout <= mem[ra];
        end
    end

endmodule

//--- rtl/wg_fifo_ram_if.sv
// weight-group FIFO RAM port bundle
// write port driven by the write side, read port by the read side,
// read data returned by the folded RAM

interface wg_fifo_ram_if
    import wg_fifo_pkg::*;
();

    // write port
    fifo_adr_t  wa;
    logic       we;
    fifo_data_t di;

    // read port
    fifo_adr_t  ra;
    logic       re;
    // valid one cycle after re
    fifo_data_t dout;

    // write side
    modport writer (
        output wa,
        output we,
        output di
    );

    // read side
    modport reader (
        output ra,
        output re,
        input  dout
    );

    // folded RAM
    modport ram (
        input  wa,
        input  we,
        input  di,
        input  ra,
        input  re,
        output dout
    );

endinterface

//--- rtl/wg_fifo_rd_ctrl.sv
// weight-group FIFO read side
// tracks the read-side count from the delayed push, prefetches one
// entry out of the RAM and holds it in the output register until
// the consumer takes it

module wg_fifo_rd_ctrl
    import wg_fifo_pkg::*;
(
    input  logic          clk_mgated,
    input  logic          reset_,
    output logic          rd_req,
    input  logic          rd_ready,
    output fifo_data_t    rd_data,
    input  logic          pushing,
    output logic          popping,
    wg_fifo_ram_if.reader ram
);

    // push seen one cycle late, so the word is already in the RAM
    logic      rd_pushing;
    // prefetch stage holds valid RAM data
    logic      rd_req_p;
    // registered output request
    logic      rd_req_int;
    logic      rd_req_next;
    // prefetch moves into the output register
    logic      rd_popping;

    // read-side count
    fifo_cnt_t rd_count_p;
    fifo_cnt_t rd_count_next_pop;
    fifo_cnt_t rd_count_next_no_pop;
    fifo_cnt_t rd_count_next;
    logic      rd_count_next_not_0;

    // read pointer
    fifo_adr_t rd_adr;
    fifo_adr_t rd_adr_next;

    // ====================
    // boundary register
    // ====================

    always_ff @(posedge clk_mgated or negedge reset_) begin
        if (!reset_) begin
            rd_pushing <= 1'b0;
        end else begin
            rd_pushing <= pushing;
        end
    end

    // pop unless the output is stalled
    assign rd_popping = rd_req_p && !(rd_req_int && !rd_ready);
    assign popping = rd_popping;

    // ====================
    // count and prefetch
    // ====================

    assign rd_count_next_pop    = rd_pushing ? rd_count_p : (rd_count_p - 1'b1);
    assign rd_count_next_no_pop = rd_pushing ? (rd_count_p + 1'b1) : rd_count_p;
    assign rd_count_next        = rd_popping ? rd_count_next_pop : rd_count_next_no_pop;
    assign rd_count_next_not_0  = (rd_count_next != '0);

    // read whenever data is there and the prefetch slot frees up
    assign ram.re = rd_count_next_not_0 && (!rd_req_p || rd_popping);

    // look one address ahead while popping
    assign rd_adr_next = rd_adr + 1'b1;
    assign ram.ra = rd_popping ? rd_adr_next : rd_adr;

    always_ff @(posedge clk_mgated or negedge reset_) begin
        if (!reset_) begin
            rd_count_p <= '0;
            rd_req_p   <= 1'b0;
            rd_adr     <= '0;
        end else begin
            if (rd_pushing || rd_popping) begin
                rd_count_p <= rd_count_next;
                rd_req_p   <= rd_count_next_not_0;
            end
            if (rd_popping) begin
                rd_adr <= rd_adr_next;
            end
        end
    end

    // ====================
    // output register
    // ====================

    // request stays up until taken
    assign rd_req_next = rd_req_p || (rd_req_int && !rd_ready);

    always_ff @(posedge clk_mgated or negedge reset_) begin
        if (!reset_) begin
            rd_req_int <= 1'b0;
        end else begin
            rd_req_int <= rd_req_next;
        end
    end

    assign rd_req = rd_req_int;

    // RAM data is valid in the cycle after re
    always_ff @(posedge clk_mgated) begin
        if (rd_popping) begin
            rd_data <= ram.dout;
        end
    end

endmodule

//--- rtl/wg_fifo_wr_ctrl.sv
// weight-group FIFO write side
// registers the incoming request and word, tracks the write-side
// occupancy and drops wr_ready when the FIFO holds FIFO_DEPTH entries;
// pushes held words into the RAM at an incrementing address

module wg_fifo_wr_ctrl
    import wg_fifo_pkg::*;
(
    input  logic          clk_mgated,
    input  logic          reset_,
    input  logic          wr_req,
    output logic          wr_ready,
    input  fifo_data_t    wr_data,
    input  logic          popping,
    output logic          pushing,
    wg_fifo_ram_if.writer ram
);

    // ====================
    // input register
    // ====================

    // registered request and word
    logic       wr_req_in;
    fifo_data_t wr_data_in;
    // input held this cycle
    logic       wr_busy_in;
    // internal copy of busy
    logic       wr_busy_int;
    logic       wr_busy_next;
    logic       wr_busy_in_next;
    logic       wr_busy_in_int;
    // held word goes into the RAM
    logic       wr_reserving;
    // pop seen one cycle late
    logic       wr_popping;

    // occupancy
    fifo_cnt_t  wr_count;
    fifo_cnt_t  wr_count_next_pop;
    fifo_cnt_t  wr_count_next_no_pop;
    fifo_cnt_t  wr_count_next;
    logic       wr_count_next_is_full;

    // RAM write pointer
    fifo_adr_t  wr_adr;

    assign wr_ready = !wr_busy_in;

    // word is pushed unless the FIFO is full
    assign wr_reserving = wr_req_in && !wr_busy_int;
    assign wr_busy_in_int = wr_req_in && wr_busy_int;

    // lookahead busy, split on wr_req for timing
    assign wr_busy_in_next = wr_req ? wr_busy_next
                                    : (wr_req_in && wr_busy_next && !wr_reserving);

    always_ff @(posedge clk_mgated or negedge reset_) begin
        if (!reset_) begin
            wr_req_in  <= 1'b0;
            wr_busy_in <= 1'b0;
        end else begin
            wr_busy_in <= wr_busy_in_next;
            // hold the request while stuck
            if (!wr_busy_in_int) begin
                wr_req_in <= wr_req && !wr_busy_in;
            end
        end
    end

    // payload capture on an accepted write
    always_ff @(posedge clk_mgated) begin
        if (!wr_busy_in && wr_req) begin
            wr_data_in <= wr_data;
        end
    end

    // ====================
    // write count
    // ====================

    assign wr_count_next_pop    = wr_reserving ? wr_count : (wr_count - 1'b1);
    assign wr_count_next_no_pop = wr_reserving ? (wr_count + 1'b1) : wr_count;
    assign wr_count_next        = wr_popping ? wr_count_next_pop : wr_count_next_no_pop;

    // a pop can never make the FIFO full
    assign wr_count_next_is_full = !wr_popping
                                && (wr_count_next_no_pop == CNT_W'(FIFO_DEPTH));
    assign wr_busy_next = wr_count_next_is_full;

    always_ff @(posedge clk_mgated or negedge reset_) begin
        if (!reset_) begin
            wr_busy_int <= 1'b0;
            wr_count    <= '0;
            wr_adr      <= '0;
            wr_popping  <= 1'b0;
        end else begin
            wr_busy_int <= wr_busy_next;
            // push and pop together cancel
            if (wr_reserving ^ wr_popping) begin
                wr_count <= wr_count_next;
            end
            if (wr_reserving) begin
                wr_adr <= wr_adr + 1'b1;
            end
            // boundary register from the read side
            wr_popping <= popping;
        end
    end

    // data enters the RAM in the same cycle
    assign pushing = wr_reserving;

    assign ram.wa = wr_adr;
    assign ram.we = wr_reserving;
    assign ram.di = wr_data_in;

endmodule

//--- sim.f
rtl/wg_fifo_pkg.sv
rtl/wg_fifo_ram_if.sv
rtl/wg_fifo_ram_array.sv
rtl/wg_fifo_folded_ram.sv
rtl/wg_fifo_wr_ctrl.sv
rtl/wg_fifo_rd_ctrl.sv
rtl/wg_fifo.sv
verif/tb_wg_fifo.sv

//--- verif/tb_wg_fifo.sv
// weight-group FIFO testbench
// directed and random traffic on both request/ready ports; every read
// is checked against a queue model, one line per test and a summary

module tb_wg_fifo
    import wg_fifo_pkg::*;
();

    // ====================
    // cycle budgets
    // ====================

    localparam int RESET_CYCLES  = 20;
    localparam int SINGLE_CYCLES = 40;
    localparam int HOLD_CYCLES   = 60;
    localparam int FILL_CYCLES   = 8 * FIFO_DEPTH;
    localparam int STREAM_WORDS  = 400;
    localparam int STREAM_CYCLES = 10 * STREAM_WORDS;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + SINGLE_CYCLES + HOLD_CYCLES
                                 + FILL_CYCLES + STREAM_CYCLES;

    logic       clk_mgated = 1'b0;
    logic       reset_;
    logic       wr_req;
    logic       wr_ready;
    fifo_data_t wr_data;
    logic       rd_req;
    logic       rd_ready;
    fifo_data_t rd_data;

    integer     seed;
    // words accepted but not yet read
    fifo_data_t model_q[$];
    string      test_name;
    int         test_errors;
    // owned by the compare process
    int         read_errors = 0;
    int         read_errors_base;
    int         pass_count;
    int         fail_count;

    wg_fifo u_wg_fifo (
        .clk_mgated (clk_mgated),
        .reset_     (reset_),
        .wr_req     (wr_req),
        .wr_ready   (wr_ready),
        .wr_data    (wr_data),
        .rd_req     (rd_req),
        .rd_ready   (rd_ready),
        .rd_data    (rd_data)
    );

    // period 4
    always #2 clk_mgated = ~clk_mgated;

    // front of the queue model
    function automatic fifo_data_t model_pop();
        fifo_data_t front;
        front = model_q.pop_front();
        return front;
    endfunction

    // ====================
    // model and compare
    // ====================

    // negedge sees the values that the next rising edge transfers
    always @(negedge clk_mgated) begin : compare_reads
        fifo_data_t expected;
        if (reset_) begin
            if (rd_req && rd_ready) begin
                assert (model_q.size() != 0) else begin
                    $display("%s: read transfer with no word outstanding", test_name);
                    read_errors++;
                end
                if (model_q.size() != 0) begin
                    expected = model_pop();
                    assert (rd_data == expected) else begin
                        $display("MISMATCH %s expected %h actual %h",
                                 test_name, expected, rd_data);
                        read_errors++;
                    end
                end
            end
            if (wr_req && wr_ready) begin
                model_q.push_back(wr_data);
            end
        end
    end

    initial begin : watchdog
        repeat (4 * TOTAL_CYCLES) @(posedge clk_mgated);
        $display("watchdog: run did not finish within %0d cycles", 4 * TOTAL_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // inputs change 1 unit after the edge
    task automatic step_cycle();
        @(posedge clk_mgated);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name        = name;
        test_errors      = 0;
        read_errors_base = read_errors;
    endtask

    task automatic finish_test();
        int errors;
        errors = test_errors + (read_errors - read_errors_base);
        if (errors == 0) begin
            pass_count++;
            $display("test %s: ok", test_name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", test_name, errors);
        end
    endtask

    // offer one random word until it is taken
    task automatic write_word();
        bit taken;
        taken   = 1'b0;
        wr_req  = 1'b1;
        wr_data = fifo_data_t'($random(seed));
        while (!taken) begin
            taken = wr_ready;
            step_cycle();
        end
        wr_req = 1'b0;
    endtask

    task automatic wait_for_rd_req(input int limit, output bit seen);
        int waited;
        waited = 0;
        while (!rd_req && waited < limit) begin
            step_cycle();
            waited++;
        end
        seen = rd_req;
    endtask

    // take everything the model still holds
    task automatic drain_fifo(input int limit);
        int waited;
        waited   = 0;
        rd_ready = 1'b1;
        while ((model_q.size() != 0 || rd_req) && waited < limit) begin
            step_cycle();
            waited++;
        end
        rd_ready = 1'b0;
        assert (model_q.size() == 0 && !rd_req) else begin
            $display("%s: FIFO did not drain within %0d cycles", test_name, limit);
            test_errors++;
        end
    endtask

    // ====================
    // tests
    // ====================

    task automatic check_reset_state();
        start_test("reset_state");
        step_cycle();
        assert (wr_ready) else begin
            $display("reset_state: wr_ready is low after reset");
            test_errors++;
        end
        assert (!rd_req) else begin
            $display("reset_state: rd_req is high after reset");
            test_errors++;
        end
        finish_test();
    endtask

    task automatic single_word();
        bit seen;
        start_test("single_word");
        write_word();
        wait_for_rd_req(SINGLE_CYCLES, seen);
        assert (seen) else begin
            $display("single_word: rd_req never rose");
            test_errors++;
        end
        if (seen) begin
            assert (rd_data == model_q[0]) else begin
                $display("MISMATCH %s expected %h actual %h",
                         test_name, model_q[0], rd_data);
                test_errors++;
            end
        end
        drain_fifo(SINGLE_CYCLES);
        finish_test();
    endtask

    task automatic hold_under_back_pressure();
        bit         seen;
        fifo_data_t held;
        start_test("back_pressure");
        write_word();
        write_word();
        wait_for_rd_req(HOLD_CYCLES, seen);
        assert (seen) else begin
            $display("back_pressure: rd_req never rose");
            test_errors++;
        end
        // oldest word in the model is the one on show
        held = model_q[0];
        // output must not move while the consumer stalls
        repeat (8) begin
            step_cycle();
            assert (rd_req) else begin
                $display("back_pressure: rd_req dropped while stalled");
                test_errors++;
            end
            assert (rd_data == held) else begin
                $display("MISMATCH %s expected %h actual %h", test_name, held, rd_data);
                test_errors++;
            end
        end
        drain_fifo(HOLD_CYCLES);
        finish_test();
    endtask

    task automatic fill_and_drain();
        int accepted;
        int low_run;
        int cycles;
        start_test("fill_and_drain");
        accepted = 0;
        low_run  = 0;
        cycles   = 0;
        rd_ready = 1'b0;
        wr_req   = 1'b1;
        // keep offering until ready has stayed low for 10 cycles
        while (low_run < 10 && cycles < FILL_CYCLES) begin
            wr_data = fifo_data_t'($random(seed));
            if (wr_ready) begin
                accepted++;
                low_run = 0;
            end else begin
                low_run++;
            end
            step_cycle();
            cycles++;
        end
        wr_req = 1'b0;
        assert (low_run >= 10) else begin
            $display("fill_and_drain: wr_ready never stayed low with reads stalled");
            test_errors++;
        end
        assert (accepted >= FIFO_DEPTH) else begin
            $display("fill_and_drain: only %0d words accepted", accepted);
            test_errors++;
        end
        drain_fifo(FILL_CYCLES);
        repeat (4) step_cycle();
        assert (wr_ready) else begin
            $display("fill_and_drain: wr_ready stayed low after the drain");
            test_errors++;
        end
        finish_test();
    endtask

    task automatic random_stream();
        logic [31:0] rnd;
        int          sent;
        int          cycles;
        start_test("random_stream");
        sent   = 0;
        cycles = 0;
        while ((sent < STREAM_WORDS || model_q.size() != 0 || rd_req)
               && cycles < STREAM_CYCLES) begin
            rnd      = $random(seed);
            wr_req   = rnd[0] && (sent < STREAM_WORDS);
            rd_ready = rnd[1];
            wr_data  = fifo_data_t'(rnd[12:8]);
            // accepted on the coming edge
            if (wr_req && wr_ready) begin
                sent++;
            end
            step_cycle();
            cycles++;
        end
        wr_req   = 1'b0;
        rd_ready = 1'b0;
        step_cycle();
        assert (sent == STREAM_WORDS && model_q.size() == 0 && !rd_req) else begin
            $display("random_stream: %0d of %0d words sent, %0d left, rd_req %b",
                     sent, STREAM_WORDS, model_q.size(), rd_req);
            test_errors++;
        end
        finish_test();
    endtask

    // ====================
    // main sequence
    // ====================

    initial begin : main
        seed        = 32'h70f1_2768;
        reset_      = 1'b0;
        wr_req      = 1'b0;
        wr_data     = '0;
        rd_ready    = 1'b0;
        test_name   = "reset";
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        repeat (16) @(posedge clk_mgated);
        #1;
        reset_ = 1'b1;

        check_reset_state();
        single_word();
        hold_under_back_pressure();
        fill_and_drain();
        random_stream();

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
